//--- filelist.f
hw/clkPkg.sv
hw/funcDecoder.sv
hw/configRegs.sv
hw/burstCounter.sv
hw/clockSequencer.sv
hw/diagReadMux.sv
hw/clkBoard.sv
testbench/clkBoardTb.sv

//--- testbench/clkBoardTb.sv
// Testbench for the EBOX clock board
// Applies a step table of strobes, readbacks and pulse checks
module clkBoardTb;

  localparam int stretchCycles = 12;
  localparam int drvDelay      = 2;
  localparam int maxSteps      = 64;
  localparam int quietWindow   = 40;
  localparam int waitLimit     = 4000;  // Worst burst is 255 pulses at rate 8

  typedef enum int {
    kindCtl, kindLd, kindRead, kindPulses, kindRun, kindQuiet, kindLevel
  } stepKindE;

  logic       CLK = 1'b0;
  logic       arstN;
  logic       diagCtlFunc;
  logic       diagLdFunc;
  logic [2:0] diagSel;
  logic [3:0] ldData;
  logic       diagRead;
  logic [5:0] readData;
  logic       eboxClkEn;
  logic       clkCrmEn;
  logic       clkEdpEn;
  logic       clkCtlEn;
  logic       mrReset;
  logic       ebusReset;

  // Step table
  stepKindE    stepKind [maxSteps];
  logic [2:0]  stepSel [maxSteps];
  logic [3:0]  stepData [maxSteps];
  int          stepExp [maxSteps];
  string       stepName [maxSteps];
  int          numSteps = 0;
  logic [31:0] lfsrState = 32'h9e6cea17;

  always #20 CLK = ~CLK;

  clkBoard #(
    .ebusResetCycles(stretchCycles)
  ) clkBoard_inst (
    .CLK(CLK), .arstN(arstN),
    .diagCtlFunc(diagCtlFunc), .diagLdFunc(diagLdFunc),
    .diagSel(diagSel), .ldData(ldData), .diagRead(diagRead),
    .readData(readData), .eboxClkEn(eboxClkEn),
    .clkCrmEn(clkCrmEn), .clkEdpEn(clkEdpEn), .clkCtlEn(clkCtlEn),
    .mrReset(mrReset), .ebusReset(ebusReset)
  );

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsrState[0]};
      if (lfsrState[0]) begin
        lfsrState = (lfsrState >> 1) ^ 32'h80200003;
      end else begin
        lfsrState = lfsrState >> 1;
      end
    end
    return val;
  endfunction

  task automatic abortRun();
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic checkEq(input string name, input logic [31:0] expVal,
                         input logic [31:0] actVal);
    if (expVal !== actVal) begin
      $display("ERR %s expected %0h actual %0h", name, expVal, actVal);
      abortRun();
    end
  endtask

  task automatic reportTimeout(input string what);
    $display("Timed out waiting for %s", what);
    abortRun();
  endtask

  // Inputs change just after the rising edge
  task automatic nextDrive();
    @(posedge CLK);
    #drvDelay;
  endtask

  task automatic addStep(input stepKindE kind, input logic [2:0] sel,
                         input logic [3:0] data, input int expVal, input string name);
    stepKind[numSteps] = kind;
    stepSel[numSteps]  = sel;
    stepData[numSteps] = data;
    stepExp[numSteps]  = expVal;
    stepName[numSteps] = name;
    numSteps++;
  endtask

  // Strobe plus one more cycle so the decoded pulse has acted
  task automatic pulseStrobe(input logic isLoad, input logic [2:0] sel,
                             input logic [3:0] data);
    nextDrive();
    diagRead = 1'b0;
    diagSel  = sel;
    ldData   = data;
    if (isLoad) begin
      diagLdFunc = 1'b1;
    end else begin
      diagCtlFunc = 1'b1;
    end
    nextDrive();
    diagCtlFunc = 1'b0;
    diagLdFunc  = 1'b0;
    diagSel     = ~sel;  // Bus moves on after the strobe cycle
    ldData      = ~data;
    nextDrive();
  endtask

  task automatic readField(input logic [2:0] sel, input int expVal, input string name);
    nextDrive();
    diagSel  = sel;
    diagRead = 1'b0;
    @(negedge CLK);
    checkEq({name, " with read low"}, 0, readData);
    nextDrive();
    diagRead = 1'b1;
    @(negedge CLK);
    checkEq(name, expVal, readData);
    nextDrive();
    diagRead = 1'b0;
  endtask

  // Count clock pulses until the status field shows idle
  task automatic countPulses(input int expCount, input string name);
    int count;
    int cyc;
    logic done;
    count    = 0;
    cyc      = 0;
    done     = 1'b0;
    diagSel  = 3'd2;
    diagRead = 1'b1;
    while (!done) begin
      @(negedge CLK);
      cyc++;
      if (cyc > waitLimit) begin
        reportTimeout({name, " to return to idle"});
      end
      if (eboxClkEn) begin
        count++;
      end
      done = (readData[5:4] == 2'd0);
    end
    checkEq(name, expCount, count);
    nextDrive();
    diagRead = 1'b0;
  endtask

  // Pulse spacing and per-domain masking while running
  task automatic checkRun(input logic [2:0] dis, input int expGap, input string name);
    int cyc;
    int last;
    int gaps;
    cyc  = 0;
    last = -1;
    gaps = 0;
    while (gaps < 4) begin
      @(negedge CLK);
      cyc++;
      if (cyc > waitLimit) begin
        reportTimeout({name, " pulses"});
      end
      checkEq({name, " crm"}, eboxClkEn & ~dis[2], clkCrmEn);
      checkEq({name, " edp"}, eboxClkEn & ~dis[1], clkEdpEn);
      checkEq({name, " ctl"}, eboxClkEn & ~dis[0], clkCtlEn);
      if (eboxClkEn) begin
        if (last >= 0) begin
          checkEq({name, " gap"}, expGap, cyc - last);
          gaps++;
        end
        last = cyc;
      end
    end
  endtask

  task automatic checkQuiet(input string name);
    int count;
    count = 0;
    repeat (quietWindow) begin
      @(negedge CLK);
      if (eboxClkEn) begin
        count++;
      end
    end
    checkEq(name, 0, count);
  endtask

  task automatic buildTable();
    logic [31:0] rnd;
    logic [1:0]  rate;
    logic [2:0]  dis;
    logic [3:0]  par;
    logic [3:0]  miscBits;
    logic [7:0]  cnt;
    rnd = randBits(2);
    rate = rnd[1:0];
    rnd = randBits(3);
    dis = rnd[2:0];
    rnd = randBits(4);
    par = rnd[3:0];
    rnd = randBits(4);
    miscBits = rnd[3:0];
    addStep(kindLd, 3'd4, {2'b00, rate}, 0, "load rate");
    addStep(kindLd, 3'd5, {1'b0, dis}, 0, "load disables");
    addStep(kindLd, 3'd6, par, 0, "load parity checks");
    addStep(kindLd, 3'd7, miscBits, 0, "load misc");
    addStep(kindRead, 3'd2, 4'd0, {rate, 2'b10}, "status after config");
    addStep(kindRead, 3'd3, 4'd0, dis, "disable readback");
    addStep(kindRead, 3'd4, 4'd0, par, "parity readback");
    addStep(kindRead, 3'd5, 4'd0, miscBits, "misc readback");
    addStep(kindRead, 3'd6, 4'd0, 0, "unused select 6");
    addStep(kindRead, 3'd7, 4'd0, 0, "unused select 7");
    rnd = randBits(8);
    cnt = (rnd[7:0] == 8'd0) ? 8'd1 : rnd[7:0];
    addStep(kindLd, 3'd2, cnt[3:0], 0, "load burst low");
    addStep(kindLd, 3'd3, cnt[7:4], 0, "load burst high");
    addStep(kindRead, 3'd0, 4'd0, cnt[7:4], "burst high readback");
    addStep(kindRead, 3'd1, 4'd0, cnt[3:0], "burst low readback");
    addStep(kindCtl, 3'd5, 4'd0, 0, "burst");
    addStep(kindPulses, 3'd0, 4'd0, cnt, "burst pulse count");
    addStep(kindRead, 3'd0, 4'd0, 0, "burst high after run");
    addStep(kindRead, 3'd1, 4'd0, 0, "burst low after run");
    addStep(kindRead, 3'd2, 4'd0, {rate, 2'b10}, "idle after burst");
    addStep(kindCtl, 3'd2, 4'd0, 0, "single step");
    addStep(kindPulses, 3'd0, 4'd0, 1, "single step pulses");
    addStep(kindCtl, 3'd4, 4'd0, 0, "conditional step");
    addStep(kindPulses, 3'd0, 4'd0, 1, "conditional step pulses");
    addStep(kindCtl, 3'd1, 4'd0, 0, "start");
    addStep(kindRun, 3'd0, {1'b0, dis}, 1 << rate, "free run");
    addStep(kindCtl, 3'd0, 4'd0, 0, "stop");
    addStep(kindQuiet, 3'd0, 4'd0, 0, "pulses after stop");
    // Second run with fresh rate and masks
    rnd = randBits(2);
    rate = rnd[1:0];
    rnd = randBits(3);
    dis = rnd[2:0];
    addStep(kindLd, 3'd4, {2'b00, rate}, 0, "reload rate");
    addStep(kindLd, 3'd5, {1'b0, dis}, 0, "reload disables");
    addStep(kindCtl, 3'd1, 4'd0, 0, "restart");
    addStep(kindRun, 3'd0, {1'b0, dis}, 1 << rate, "masked run");
    addStep(kindCtl, 3'd3, 4'd0, 0, "ebox ss stop");
    addStep(kindQuiet, 3'd0, 4'd0, 0, "pulses after ebox ss");
    addStep(kindCtl, 3'd7, 4'd0, 0, "set reset function");
    addStep(kindLevel, 3'd0, 4'd0, 0, "mrReset cleared");
    addStep(kindRead, 3'd2, 4'd0, {rate, 2'b00}, "status reset cleared");
    addStep(kindCtl, 3'd6, 4'd0, 0, "clear reset function");
    addStep(kindLevel, 3'd0, 4'd0, 1, "mrReset set");
    addStep(kindRead, 3'd2, 4'd0, {rate, 2'b10}, "status reset set");
  endtask

  initial begin
    int highCycles;
    int waitCyc;
    logic done;
    arstN       = 1'b0;
    diagCtlFunc = 1'b0;
    diagLdFunc  = 1'b0;
    diagSel     = 3'd0;
    ldData      = 4'd0;
    diagRead    = 1'b0;
    buildTable();
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    checkEq("clock enable in reset", 0, eboxClkEn);
    checkEq("mrReset in reset", 1, mrReset);
    checkEq("ebusReset in reset", 1, ebusReset);
    nextDrive();
    arstN = 1'b1;  // Fourth edge done

    // Bus reset stretch after release
    highCycles = 0;
    waitCyc    = 0;
    done       = 1'b0;
    while (!done) begin
      @(negedge CLK);
      waitCyc++;
      if (waitCyc > waitLimit) begin
        reportTimeout("bus reset to end");
      end
      if (ebusReset) begin
        highCycles++;
      end else begin
        done = 1'b1;
      end
    end
    checkEq("bus reset stretch", stretchCycles, highCycles);
    repeat (quietWindow) begin
      @(negedge CLK);
      checkEq("bus reset stays low", 0, ebusReset);
      checkEq("no clock after reset", 0, eboxClkEn);
      checkEq("mrReset after reset", 1, mrReset);
    end

    for (int i = 0; i < numSteps; i++) begin
      case (stepKind[i])
        kindCtl:    pulseStrobe(1'b0, stepSel[i], 4'd0);
        kindLd:     pulseStrobe(1'b1, stepSel[i], stepData[i]);
        kindRead:   readField(stepSel[i], stepExp[i], stepName[i]);
        kindPulses: countPulses(stepExp[i], stepName[i]);
        kindRun:    checkRun(stepData[i][2:0], stepExp[i], stepName[i]);
        kindQuiet:  checkQuiet(stepName[i]);
        default: begin
          @(negedge CLK);
          checkEq(stepName[i], stepExp[i], mrReset);
        end
      endcase
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- hw/clkBoard.sv
// EBOX clock board top level
// Decoder, registers, burst counter, sequencer and readback mux
module clkBoard #(
  parameter int ebusResetCycles = 12
) (
  input  logic            CLK,
  input  logic            arstN,
  input  logic            diagCtlFunc,
  input  logic            diagLdFunc,
  input  clkPkg::diagSelT  diagSel,
  input  clkPkg::ldDataT   ldData,
  input  logic            diagRead,
  output clkPkg::readDataT readData,
  output logic            eboxClkEn,
  output logic            clkCrmEn,
  output logic            clkEdpEn,
  output logic            clkCtlEn,
  output logic            mrReset,
  output logic            ebusReset
);
  import clkPkg::*;

  // Function pulses
  logic start;
  logic stop;
  logic step;
  logic burst;
  logic clrReset;
  logic setReset;
  logic ldBurstLo;
  logic ldBurstHi;
  logic ldRate;
  logic ldDisable;
  logic ldParCheck;
  logic ldMisc;

  rateSelT    rateSel;
  logic       crmDis;
  logic       edpDis;
  logic       ctlDis;
  ldDataT     parCheck;
  ldDataT     misc;
  burstCountT burstCount;
  logic       burstZero;
  logic       burstTick;
  runStateE   runState;

  funcDecoder funcDecoder_inst (
    .CLK(CLK), .arstN(arstN),
    .diagCtlFunc(diagCtlFunc), .diagLdFunc(diagLdFunc), .diagSel(diagSel),
    .start(start), .stop(stop), .step(step), .burst(burst),
    .clrReset(clrReset), .setReset(setReset),
    .ldBurstLo(ldBurstLo), .ldBurstHi(ldBurstHi), .ldRate(ldRate),
    .ldDisable(ldDisable), .ldParCheck(ldParCheck), .ldMisc(ldMisc)
  );

  configRegs configRegs_inst (
    .CLK(CLK), .arstN(arstN),
    .ldRate(ldRate), .ldDisable(ldDisable), .ldParCheck(ldParCheck),
    .ldMisc(ldMisc), .ldData(ldData),
    .rateSel(rateSel), .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis),
    .parCheck(parCheck), .misc(misc)
  );

  burstCounter burstCounter_inst (
    .CLK(CLK), .arstN(arstN),
    .ldBurstLo(ldBurstLo), .ldBurstHi(ldBurstHi), .burstTick(burstTick),
    .ldData(ldData), .burstCount(burstCount), .burstZero(burstZero)
  );

  clockSequencer #(
    .ebusResetCycles(ebusResetCycles)
  ) clockSequencer_inst (
    .CLK(CLK), .arstN(arstN),
    .start(start), .stop(stop), .step(step), .burst(burst),
    .clrReset(clrReset), .setReset(setReset),
    .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis),
    .burstZero(burstZero), .rateSel(rateSel), .runState(runState),
    .eboxClkEn(eboxClkEn), .clkCrmEn(clkCrmEn), .clkEdpEn(clkEdpEn),
    .clkCtlEn(clkCtlEn), .burstTick(burstTick),
    .mrReset(mrReset), .ebusReset(ebusReset)
  );

  diagReadMux diagReadMux_inst (
    .diagRead(diagRead), .diagSel(diagSel), .burstCount(burstCount),
    .runState(runState), .rateSel(rateSel),
    .mrReset(mrReset), .ebusReset(ebusReset),
    .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis),
    .parCheck(parCheck), .misc(misc), .readData(readData)
  );

endmodule

//--- hw/diagReadMux.sv
// Diagnostic readback multiplexer
// Returns one 6-bit status field per select while diagRead is high
module diagReadMux (
  input  logic              diagRead,
  input  clkPkg::diagSelT    diagSel,
  input  clkPkg::burstCountT burstCount,
  input  clkPkg::runStateE   runState,
  input  clkPkg::rateSelT    rateSel,
  input  logic              mrReset,
  input  logic              ebusReset,
  input  logic              crmDis,
  input  logic              edpDis,
  input  logic              ctlDis,
  input  clkPkg::ldDataT     parCheck,
  input  clkPkg::ldDataT     misc,
  output clkPkg::readDataT   readData
);

  always_comb begin
    readData = '0;
    if (diagRead) begin
      case (diagSel)
        3'd0: readData = {2'b00, burstCount[7:4]};
        3'd1: readData = {2'b00, burstCount[3:0]};
        3'd2: begin
          // Status word fills all six bits
          readData = {runState, rateSel, mrReset, ebusReset};
        end
        3'd3: readData = {3'b000, crmDis, edpDis, ctlDis};
        3'd4: readData = {2'b00, parCheck};
        3'd5: readData = {2'b00, misc};
        default: readData = '0;  // Selects 6 and 7 unused
      endcase
    end
  end

endmodule

//--- hw/clockSequencer.sv
// EBOX clock sequencer
// Run state machine, rate divider, machine reset and bus reset stretch
module clockSequencer #(
  parameter int ebusResetCycles = 12
) (
  input  logic            CLK,
  input  logic            arstN,
  input  logic            start,
  input  logic            stop,
  input  logic            step,
  input  logic            burst,
  input  logic            clrReset,
  input  logic            setReset,
  input  logic            crmDis,
  input  logic            edpDis,
  input  logic            ctlDis,
  input  logic            burstZero,
  input  clkPkg::rateSelT  rateSel,
  output clkPkg::runStateE runState,
  output logic            eboxClkEn,
  output logic            clkCrmEn,
  output logic            clkEdpEn,
  output logic            clkCtlEn,
  output logic            burstTick,
  output logic            mrReset,
  output logic            ebusReset
);
  import clkPkg::*;

  localparam int rstCntW = $clog2(ebusResetCycles + 1);

  logic [2:0]         rateDiv;
  logic [2:0]         rateMask;
  logic               rateTick;
  runStateE           nextState;
  logic [rstCntW-1:0] rstCnt;

  // Free running divider, tick every 2**rateSel cycles
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      rateDiv <= '0;
    end else begin
      rateDiv <= rateDiv + 3'd1;
    end
  end

  always_comb begin
    case (rateSel)
      2'd0:    rateMask = 3'b000;
      2'd1:    rateMask = 3'b001;
      2'd2:    rateMask = 3'b011;
      default: rateMask = 3'b111;
    endcase
  end

  assign rateTick = ((rateDiv & rateMask) == 3'b000);

  // Stop has priority over any new run request
  always_comb begin
    nextState = runState;
    if (stop) begin
      nextState = runIdle;
    end else if (start) begin
      nextState = runFree;
    end else if (burst) begin
      nextState = runBurst;
    end else if (step) begin
      nextState = runStep;
    end else if (rateTick) begin
      case (runState)
        runBurst: if (burstZero) nextState = runIdle;
        runStep:  nextState = runIdle;  // One pulse then done
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      runState <= runIdle;
    end else begin
      runState <= nextState;
    end
  end

  // Clock pulses decided from the current state
  always_comb begin
    eboxClkEn = 1'b0;
    burstTick = 1'b0;
    if (rateTick) begin
      case (runState)
        runFree: eboxClkEn = 1'b1;
        runStep: eboxClkEn = 1'b1;
        runBurst: begin
          eboxClkEn = !burstZero;
          burstTick = !burstZero;
        end
        default: ;
      endcase
    end
  end

  assign clkCrmEn = eboxClkEn & ~crmDis;
  assign clkEdpEn = eboxClkEn & ~edpDis;
  assign clkCtlEn = eboxClkEn & ~ctlDis;

  // Machine reset is asserted out of reset
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      mrReset <= 1'b1;
    end else if (clrReset) begin
      mrReset <= 1'b1;
    end else if (setReset) begin
      mrReset <= 1'b0;
    end
  end

  // Bus reset stretch, counter saturates at the end
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      rstCnt <= '0;
    end else if (ebusReset) begin
      rstCnt <= rstCnt + 1'b1;
    end
  end

  assign ebusReset = (rstCnt != rstCntW'(ebusResetCycles));

endmodule

//--- hw/burstCounter.sv
// Burst counter
// Loaded a nibble at a time, counts down once per burst clock
module burstCounter (
  input  logic              CLK,
  input  logic              arstN,
  input  logic              ldBurstLo,
  input  logic              ldBurstHi,
  input  logic              burstTick,
  input  clkPkg::ldDataT     ldData,
  output clkPkg::burstCountT burstCount,
  output logic              burstZero
);
  import clkPkg::*;

  ldDataT ldDataQ;  // Bus data from the strobe cycle

  // Aligns the data with the decoded load pulse
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      ldDataQ <= '0;
    end else begin
      ldDataQ <= ldData;
    end
  end

  // Loads win over a tick in the same cycle
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      burstCount <= '0;
    end else if (ldBurstLo) begin
      burstCount <= {burstCount[7:4], ldDataQ};
    end else if (ldBurstHi) begin
      burstCount <= {ldDataQ, burstCount[3:0]};
    end else if (burstTick) begin
      burstCount <= burstCount - 8'd1;  // Sequencer never ticks at zero
    end
  end

  assign burstZero = (burstCount == '0);

endmodule

//--- hw/configRegs.sv
// Clock board configuration registers
// Rate select, domain disables, parity checks and miscellaneous bits
module configRegs (
  input  logic          CLK,
  input  logic          arstN,
  input  logic          ldRate,
  input  logic          ldDisable,
  input  logic          ldParCheck,
  input  logic          ldMisc,
  input  clkPkg::ldDataT ldData,
  output clkPkg::rateSelT rateSel,
  output logic          crmDis,
  output logic          edpDis,
  output logic          ctlDis,
  output clkPkg::ldDataT parCheck,
  output clkPkg::ldDataT misc
);
  import clkPkg::*;

  ldDataT ldDataQ;  // Bus data from the strobe cycle

  // Aligns the data with the decoded load pulse
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      ldDataQ <= '0;
    end else begin
      ldDataQ <= ldData;
    end
  end

  // Function 044 loads only the rate
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      rateSel <= '0;
    end else if (ldRate) begin
      rateSel <= ldDataQ[1:0];
    end
  end

  // Function 045 takes bus bits 33 to 35
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      crmDis <= 1'b0;
      edpDis <= 1'b0;
      ctlDis <= 1'b0;
    end else if (ldDisable) begin
      crmDis <= ldDataQ[2];
      edpDis <= ldDataQ[1];
      ctlDis <= ldDataQ[0];
    end
  end

  // Functions 046 and 047 are only stored for readback
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      parCheck <= '0;
      misc     <= '0;
    end else begin
      if (ldParCheck) begin
        parCheck <= ldDataQ;
      end
      if (ldMisc) begin
        misc <= ldDataQ;
      end
    end
  end

endmodule

//--- hw/funcDecoder.sv
// Diagnostic function decoder
// Registers bus strobes and turns them into one-cycle function pulses
module funcDecoder (
  input  logic           CLK,
  input  logic           arstN,
  input  logic           diagCtlFunc,
  input  logic           diagLdFunc,
  input  clkPkg::diagSelT diagSel,
  output logic           start,
  output logic           stop,
  output logic           step,
  output logic           burst,
  output logic           clrReset,
  output logic           setReset,
  output logic           ldBurstLo,
  output logic           ldBurstHi,
  output logic           ldRate,
  output logic           ldDisable,
  output logic           ldParCheck,
  output logic           ldMisc
);
  import clkPkg::*;

  logic    ctlQ;
  logic    ldQ;
  diagSelT selQ;
  ctlFuncE ctlCode;
  ldFuncE  ldCode;

  // Capture strobe and select in the same cycle
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      ctlQ <= 1'b0;
      ldQ  <= 1'b0;
      selQ <= '0;
    end else begin
      ctlQ <= diagCtlFunc;
      ldQ  <= diagLdFunc;
      selQ <= diagSel;
    end
  end

  assign ctlCode = ctlFuncE'(selQ);
  assign ldCode  = ldFuncE'(selQ);

  always_comb begin
    start    = 1'b0;
    stop     = 1'b0;
    step     = 1'b0;
    burst    = 1'b0;
    clrReset = 1'b0;
    setReset = 1'b0;
    if (ctlQ) begin
      case (ctlCode)
        funcStop, funcEboxSs:       stop     = 1'b1;
        funcStart:                  start    = 1'b1;
        funcSingleStep, funcCondSs: step     = 1'b1;
        funcBurst:                  burst    = 1'b1;
        funcClrReset:               clrReset = 1'b1;
        funcSetReset:               setReset = 1'b1;
        default: ;
      endcase
    end
  end

  always_comb begin
    ldBurstLo  = 1'b0;
    ldBurstHi  = 1'b0;
    ldRate     = 1'b0;
    ldDisable  = 1'b0;
    ldParCheck = 1'b0;
    ldMisc     = 1'b0;
    if (ldQ) begin
      case (ldCode)
        ld042:   ldBurstLo  = 1'b1;
        ld043:   ldBurstHi  = 1'b1;
        ld044:   ldRate     = 1'b1;
        ld045:   ldDisable  = 1'b1;
        ld046:   ldParCheck = 1'b1;
        ld047:   ldMisc     = 1'b1;
        default: ;  // 040 and 041 do nothing
      endcase
    end
  end

endmodule

//--- hw/clkPkg.sv
// EBOX clock board shared definitions
// Function codes, sequencer state and field types
package clkPkg;

  // Diagnostic function select, bus bits 4 to 6
  typedef logic [2:0] diagSelT;

  // Load data nibble, bus bits 32 to 35 (bit 3 is bus bit 32)
  typedef logic [3:0] ldDataT;

  // Diagnostic readback field
  typedef logic [5:0] readDataT;

  typedef logic [7:0] burstCountT;

  // Clock rate, divides by 1, 2, 4 or 8
  typedef logic [1:0] rateSelT;

  // Control functions 000 to 007
  typedef enum logic [2:0] {
    funcStop       = 3'd0,
    funcStart      = 3'd1,
    funcSingleStep = 3'd2,
    funcEboxSs     = 3'd3,  // Acts as stop
    funcCondSs     = 3'd4,  // Acts as single step
    funcBurst      = 3'd5,
    funcClrReset   = 3'd6,
    funcSetReset   = 3'd7
  } ctlFuncE;

  // Load functions 040 to 047
  typedef enum logic [2:0] {
    ldUnused0 = 3'd0,
    ldUnused1 = 3'd1,
    ld042     = 3'd2,  // Burst count low nibble
    ld043     = 3'd3,  // Burst count high nibble
    ld044     = 3'd4,  // Rate select
    ld045     = 3'd5,  // Domain disables
    ld046     = 3'd6,  // Parity check enables
    ld047     = 3'd7   // Miscellaneous bits
  } ldFuncE;

  // Clock sequencer run state
  typedef enum logic [1:0] {
    runIdle  = 2'd0,
    runFree  = 2'd1,
    runBurst = 2'd2,
    runStep  = 2'd3
  } runStateE;

endpackage
